/* verilog/bus_pkg.sv */
package bus_pkg;

    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t; // Word address, not byte address.

    // One bus request. rw high means write.
    typedef struct packed {
        logic  valid;
        logic  rw;
        addr_t addr;
        word_t data;
    } bus_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } bus_rsp_t;

    // Credits the requester owns when it leaves reset.
    localparam int BUS_CREDITS = 2;

    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    localparam addr_t SEG7_ADDR  = 12'h100;
    localparam addr_t VIDEO_ADDR = 12'h200;
    localparam int    VIDEO_AW   = 2; // Four word slots, the last one unused.

    typedef enum logic [1:0] {
        T_RAM,
        T_SEG7,
        T_VIDEO,
        T_NONE
    } target_t;

endpackage

/* verilog/periph_pkg.sv */
package periph_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  seg_t;  // Active low, bit 7 is the decimal point.
    typedef logic [3:0]  an_t;   // Active low digit enables.
    typedef logic [15:0] disp_t;

    // Video register defaults.
    localparam byte_t VIDEO_CTL_DEFAULT = 8'b11000111;
    localparam byte_t CRX_DEFAULT       = 8'd1;
    localparam byte_t CRY_DEFAULT       = 8'd1;

    // Each digit stays lit for this many clocks before the scan moves on.
    localparam int SCAN_CYCLES = 4;
    localparam int SCAN_W      = $clog2(SCAN_CYCLES);
    localparam int DIGIT_W     = $clog2($bits(an_t));

endpackage

/* verilog/mmio_decode.sv */
module mmio_decode (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp,
    output logic              credit,
    output bus_pkg::bus_req_t stage,
    output logic              sel_ram,
    output logic              sel_seg7,
    output logic              sel_video,
    input  bus_pkg::word_t    ram_rd,
    input  bus_pkg::word_t    seg7_rd,
    input  bus_pkg::word_t    video_rd
);

    bus_pkg::bus_req_t stage_q;
    bus_pkg::target_t  tgt_q;
    bus_pkg::target_t  tgt_d2;
    logic              vld_d2;
    logic              rd_d2;

    function automatic bus_pkg::target_t decode(input bus_pkg::addr_t a);
        bus_pkg::target_t t;
        if (a[bus_pkg::ADDR_W-1:bus_pkg::RAM_AW] == '0) begin
            t = bus_pkg::T_RAM;
        end else if (a == bus_pkg::SEG7_ADDR) begin
            t = bus_pkg::T_SEG7;
        end else if (a[bus_pkg::ADDR_W-1:bus_pkg::VIDEO_AW] ==
                     bus_pkg::VIDEO_ADDR[bus_pkg::ADDR_W-1:bus_pkg::VIDEO_AW]) begin
            t = bus_pkg::T_VIDEO;
        end else begin
            t = bus_pkg::T_NONE; // Unmapped, answered with zero.
        end
        return t;
    endfunction

    // First stage: capture the request and its target.
    always_ff @(posedge clk) begin
        if (rst) begin
            stage_q.valid <= 1'b0;
        end else begin
            stage_q.valid <= req.valid;
        end
        stage_q.rw   <= req.rw;
        stage_q.addr <= req.addr;
        stage_q.data <= req.data;
        tgt_q        <= decode(req.addr);
    end

    assign stage     = stage_q;
    assign sel_ram   = stage_q.valid && (tgt_q == bus_pkg::T_RAM);
    assign sel_seg7  = stage_q.valid && (tgt_q == bus_pkg::T_SEG7);
    assign sel_video = stage_q.valid && (tgt_q == bus_pkg::T_VIDEO);

    // Second stage lines up with the registered target read data.
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_d2 <= 1'b0;
        end else begin
            vld_d2 <= stage_q.valid;
        end
        tgt_d2 <= tgt_q;
        rd_d2  <= !stage_q.rw;
    end

    always_comb begin
        rsp.valid = vld_d2;
        rsp.data  = '0; // Writes and unmapped reads return zero.
        if (vld_d2 && rd_d2) begin
            case (tgt_d2)
                bus_pkg::T_RAM:   rsp.data = ram_rd;
                bus_pkg::T_SEG7:  rsp.data = seg7_rd;
                bus_pkg::T_VIDEO: rsp.data = video_rd;
                default:          rsp.data = '0;
            endcase
        end
    end

    assign credit = vld_d2; // Every response hands one credit back.

endmodule

/* verilog/block_ram.sv */
module block_ram (
    input  logic              clk,
    input  bus_pkg::bus_req_t stage,
    input  logic              sel,
    output bus_pkg::word_t    rd
);

    bus_pkg::word_t            mem [bus_pkg::RAM_WORDS];
    logic [bus_pkg::RAM_AW-1:0] idx;

    assign idx = stage.addr[bus_pkg::RAM_AW-1:0];

    // Read is registered every cycle; the decoder only keeps it when selected.
    always_ff @(posedge clk) begin
        if (sel && stage.rw) begin
            mem[idx] <= stage.data;
        end
        rd <= mem[idx];
    end

endmodule

/* verilog/ctl_regs.sv */
module ctl_regs (
    input  logic                clk,
    input  logic                rst,
    input  bus_pkg::bus_req_t   stage,
    input  logic                sel,
    output bus_pkg::word_t      rd,
    output periph_pkg::byte_t   vga_ctl,
    output periph_pkg::byte_t   crx,
    output periph_pkg::byte_t   cry
);

    logic [bus_pkg::VIDEO_AW-1:0] idx;
    periph_pkg::byte_t            rd_byte;

    assign idx = stage.addr[bus_pkg::VIDEO_AW-1:0];

    // Index 0 is control, 1 is cursor x, 2 is cursor y.
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_ctl <= periph_pkg::VIDEO_CTL_DEFAULT;
            crx     <= periph_pkg::CRX_DEFAULT;
            cry     <= periph_pkg::CRY_DEFAULT;
        end else if (sel && stage.rw) begin
            case (idx)
                2'd0:    vga_ctl <= stage.data[7:0];
                2'd1:    crx     <= stage.data[7:0];
                2'd2:    cry     <= stage.data[7:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (idx)
            2'd0:    rd_byte = vga_ctl;
            2'd1:    rd_byte = crx;
            2'd2:    rd_byte = cry;
            default: rd_byte = '0; // Slot 3 is empty.
        endcase
    end

    always_ff @(posedge clk) begin
        rd <= {{($bits(bus_pkg::word_t) - $bits(periph_pkg::byte_t)){1'b0}}, rd_byte};
    end

endmodule

/* verilog/seg7_display.sv */
module seg7_display (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::bus_req_t stage,
    input  logic              sel,
    output bus_pkg::word_t    rd,
    output periph_pkg::seg_t  seg,
    output periph_pkg::an_t   an
);

    periph_pkg::disp_t                  value;
    logic [periph_pkg::SCAN_W-1:0]      scan_cnt;
    logic [periph_pkg::DIGIT_W-1:0]     digit;
    logic [3:0]                         nibble;

    // Segment patterns are active low, decimal point kept dark.
    function automatic periph_pkg::seg_t hex_to_seg(input logic [3:0] h);
        periph_pkg::seg_t s;
        case (h)
            4'h0: s = 8'hC0;
            4'h1: s = 8'hF9;
            4'h2: s = 8'hA4;
            4'h3: s = 8'hB0;
            4'h4: s = 8'h99;
            4'h5: s = 8'h92;
            4'h6: s = 8'h82;
            4'h7: s = 8'hF8;
            4'h8: s = 8'h80;
            4'h9: s = 8'h90;
            4'hA: s = 8'h88;
            4'hB: s = 8'h83;
            4'hC: s = 8'hC6;
            4'hD: s = 8'hA1;
            4'hE: s = 8'h86;
            default: s = 8'h8E;
        endcase
        return s;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            value <= '0;
        end else if (sel && stage.rw) begin
            value <= stage.data[$bits(periph_pkg::disp_t)-1:0];
        end
    end

    always_ff @(posedge clk) begin
        rd <= {{($bits(bus_pkg::word_t) - $bits(periph_pkg::disp_t)){1'b0}}, value};
    end

    // Advance to the next digit once the current one has been lit long enough.
    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt <= '0;
            digit    <= '0;
        end else if (scan_cnt == periph_pkg::SCAN_W'(periph_pkg::SCAN_CYCLES - 1)) begin
            scan_cnt <= '0;
            digit    <= digit + 1'b1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign nibble = value[digit*4 +: 4];

    always_ff @(posedge clk) begin
        if (rst) begin
            an  <= '1; // Nothing lit.
            seg <= '1;
        end else begin
            an  <= ~(periph_pkg::an_t'(1) << digit);
            seg <= hex_to_seg(nibble);
        end
    end

endmodule

/* verilog/periph_top.sv */
module periph_top (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp,
    output logic              credit,
    output periph_pkg::seg_t  seg,
    output periph_pkg::an_t   an,
    output periph_pkg::byte_t vga_ctl,
    output periph_pkg::byte_t crx,
    output periph_pkg::byte_t cry
);

    bus_pkg::bus_req_t stage;
    logic              sel_ram;
    logic              sel_seg7;
    logic              sel_video;
    bus_pkg::word_t    ram_rd;
    bus_pkg::word_t    seg7_rd;
    bus_pkg::word_t    video_rd;

    mmio_decode decode (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .rsp       (rsp),
        .credit    (credit),
        .stage     (stage),
        .sel_ram   (sel_ram),
        .sel_seg7  (sel_seg7),
        .sel_video (sel_video),
        .ram_rd    (ram_rd),
        .seg7_rd   (seg7_rd),
        .video_rd  (video_rd)
    );

    block_ram ram (
        .clk   (clk),
        .stage (stage),
        .sel   (sel_ram),
        .rd    (ram_rd)
    );

    seg7_display seg7 (
        .clk   (clk),
        .rst   (rst),
        .stage (stage),
        .sel   (sel_seg7),
        .rd    (seg7_rd),
        .seg   (seg),
        .an    (an)
    );

    // Values that would drive the text-mode scanout.
    ctl_regs video_ctl (
        .clk     (clk),
        .rst     (rst),
        .stage   (stage),
        .sel     (sel_video),
        .rd      (video_rd),
        .vga_ctl (vga_ctl),
        .crx     (crx),
        .cry     (cry)
    );

endmodule

/* dv/periph_tb.sv */
module periph_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 50; // Clocks any single wait may take.

    logic              clk;
    logic              rst;
    bus_pkg::bus_req_t req;
    bus_pkg::bus_rsp_t rsp;
    logic              credit;
    periph_pkg::seg_t  seg;
    periph_pkg::an_t   an;
    periph_pkg::byte_t vga_ctl;
    periph_pkg::byte_t crx;
    periph_pkg::byte_t cry;

    integer seed;
    int     cycle;
    int     credits;
    int     errors;
    int     tests;
    int     failed_tests;
    int     test_errors;
    string  test_name;
    bit     aborted;

    // Expected responses in issue order, with the edge number that accepted each request.
    bus_pkg::word_t    exp_data[$];
    int                exp_edge[$];
    bus_pkg::word_t    ram_model[bus_pkg::RAM_WORDS];
    logic              ram_written[bus_pkg::RAM_WORDS];
    periph_pkg::byte_t video_model[3];
    periph_pkg::disp_t disp_model;

    periph_top dut0 (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .rsp     (rsp),
        .credit  (credit),
        .seg     (seg),
        .an      (an),
        .vga_ctl (vga_ctl),
        .crx     (crx),
        .cry     (cry)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Standard gfedcba patterns, inverted because the segments are active low.
    function automatic periph_pkg::seg_t expected_seg(input logic [3:0] h);
        logic [6:0] on;
        case (h)
            4'h0: on = 7'h3F;
            4'h1: on = 7'h06;
            4'h2: on = 7'h5B;
            4'h3: on = 7'h4F;
            4'h4: on = 7'h66;
            4'h5: on = 7'h6D;
            4'h6: on = 7'h7D;
            4'h7: on = 7'h07;
            4'h8: on = 7'h7F;
            4'h9: on = 7'h6F;
            4'hA: on = 7'h77;
            4'hB: on = 7'h7C;
            4'hC: on = 7'h39;
            4'hD: on = 7'h5E;
            4'hE: on = 7'h79;
            default: on = 7'h71;
        endcase
        return ~{1'b0, on}; // Decimal point stays dark.
    endfunction

    function automatic bus_pkg::word_t model_read(input bus_pkg::addr_t a);
        if (a < bus_pkg::RAM_WORDS) begin
            return ram_model[a];
        end else if (a == bus_pkg::SEG7_ADDR) begin
            return {16'b0, disp_model};
        end else if (a >= bus_pkg::VIDEO_ADDR && a < bus_pkg::VIDEO_ADDR + 3) begin
            return {24'b0, video_model[a - bus_pkg::VIDEO_ADDR]};
        end
        return '0;
    endfunction

    task automatic model_write(input bus_pkg::addr_t a, input bus_pkg::word_t d);
        if (a < bus_pkg::RAM_WORDS) begin
            ram_model[a]   = d;
            ram_written[a] = 1'b1;
        end else if (a == bus_pkg::SEG7_ADDR) begin
            disp_model = d[15:0];
        end else if (a >= bus_pkg::VIDEO_ADDR && a < bus_pkg::VIDEO_ADDR + 3) begin
            video_model[a - bus_pkg::VIDEO_ADDR] = d[7:0];
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    task automatic check_word(input string what, input bus_pkg::word_t exp,
                              input bus_pkg::word_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_byte(input string what, input periph_pkg::byte_t exp,
                              input periph_pkg::byte_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_seg(input string what, input periph_pkg::seg_t exp,
                             input periph_pkg::seg_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_an(input string what, input periph_pkg::an_t exp,
                            input periph_pkg::an_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // After a timeout no further request goes out and no wait blocks again.
    task automatic timeout_abort(input string msg);
        errors++;
        aborted = 1'b1;
        $display("Timeout in %s: %s", test_name, msg);
    endtask

    // Moves to the next falling edge, idles the bus and checks any response.
    task automatic tick();
        int acc;
        @(negedge clk);
        req = '0;
        if (credit !== rsp.valid) begin
            report_error("credit pulse does not line up with rsp.valid");
        end
        if (rsp.valid === 1'b1) begin
            if (exp_data.size() == 0) begin
                report_error("response arrived with no request outstanding");
            end else begin
                check_word("read data", exp_data.pop_front(), rsp.data);
                acc = exp_edge.pop_front();
                if (cycle + 1 - acc != 2) begin // The coming edge captures it.
                    report_error($sformatf("response took %0d cycles instead of 2",
                                           cycle + 1 - acc));
                end
            end
        end
        if (credit === 1'b1) begin
            credits++;
        end
    endtask

    task automatic wait_credit();
        int waited;
        waited = 0;
        while (credits == 0 && waited < WAIT_LIMIT && !aborted) begin
            tick();
            waited++;
        end
        if (credits == 0 && !aborted) begin
            timeout_abort("no credit came back to the requester");
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_data.size() != 0 && waited < WAIT_LIMIT && !aborted) begin
            tick();
            waited++;
        end
        if (exp_data.size() != 0 && !aborted) begin
            timeout_abort("outstanding responses never arrived");
        end
    endtask

    task automatic issue(input logic rw, input bus_pkg::addr_t a, input bus_pkg::word_t d);
        wait_credit();
        if (aborted) begin
            return;
        end
        req.valid = 1'b1;
        req.rw    = rw;
        req.addr  = a;
        req.data  = d;
        credits--;
        if (rw) begin
            model_write(a, d);
            exp_data.push_back('0);
        end else begin
            exp_data.push_back(model_read(a));
        end
        exp_edge.push_back(cycle + 1);
        tick();
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
        tests++;
    endtask

    task automatic end_test();
        drain();
        if (errors != test_errors) begin
            failed_tests++;
            $display("Test %s: failed with %0d errors", test_name, errors - test_errors);
        end else begin
            $display("Test %s: passed", test_name);
        end
    endtask

    task automatic check_ports();
        check_byte("vga_ctl", video_model[0], vga_ctl);
        check_byte("crx", video_model[1], crx);
        check_byte("cry", video_model[2], cry);
    endtask

    task automatic reset_values_test();
        start_test("reset_defaults");
        check_ports();
        check_an("an", '1, an);
        if (rsp.valid !== 1'b0 || credit !== 1'b0) begin
            report_error("rsp.valid or credit is high right after reset");
        end
        issue(1'b0, bus_pkg::SEG7_ADDR, '0);
        end_test();
    endtask

    task automatic ram_traffic_test();
        bus_pkg::addr_t a;
        logic           rw;
        start_test("ram_random");
        for (int i = 0; i < 200; i++) begin
            a  = bus_pkg::addr_t'($random(seed) & 8'hff);
            rw = (($random(seed) & 1) == 1) || !ram_written[a]; // Never read undefined words.
            issue(rw, a, $random(seed));
        end
        end_test();
    endtask

    task automatic video_reg_test();
        start_test("video_regs");
        for (int i = 0; i < 12; i++) begin
            issue(1'b1, bus_pkg::VIDEO_ADDR + ($random(seed) & 3), $random(seed));
            drain();
            check_ports();
            for (int j = 0; j < 4; j++) begin
                issue(1'b0, bus_pkg::VIDEO_ADDR + j, '0);
            end
        end
        end_test();
    endtask

    task automatic display_scan_test();
        int            digit;
        logic [3:0]    seen;
        start_test("display_scan");
        for (int i = 0; i < 5; i++) begin
            issue(1'b1, bus_pkg::SEG7_ADDR, $random(seed));
            issue(1'b0, bus_pkg::SEG7_ADDR, '0);
            drain();
            seen = '0;
            for (int c = 0; c < 4 * periph_pkg::SCAN_CYCLES; c++) begin
                tick();
                if ($countones(~an) != 1) begin
                    report_error($sformatf("an is %b, not exactly one digit lit", an));
                end else begin
                    digit = 0;
                    for (int d = 0; d < 4; d++) begin
                        if (an[d] == 1'b0) digit = d;
                    end
                    seen[digit] = 1'b1;
                    check_seg("seg", expected_seg(disp_model[digit*4 +: 4]), seg);
                end
            end
            if (seen != 4'hF) begin
                report_error($sformatf("only digits %b were lit during one scan", seen));
            end
        end
        end_test();
    endtask

    task automatic unmapped_test();
        bus_pkg::addr_t addrs[$];
        start_test("unmapped");
        addrs = '{12'h300, 12'h101, 12'h1FF, 12'h204, 12'hFFF};
        for (int i = 0; i < 5; i++) begin
            addrs.push_back(bus_pkg::addr_t'(12'h300 + ($random(seed) & 12'h3ff)));
        end
        // RAM words under the same low address bits expose a write that leaks into the RAM.
        foreach (addrs[i]) begin
            issue(1'b1, addrs[i] & 12'h0ff, $random(seed));
        end
        foreach (addrs[i]) begin
            issue(1'b1, addrs[i], $random(seed));
            issue(1'b0, addrs[i], '0);
        end
        drain();
        if (credits != bus_pkg::BUS_CREDITS) begin
            report_error($sformatf("requester holds %0d credits after draining", credits));
        end
        check_ports();
        issue(1'b0, bus_pkg::SEG7_ADDR, '0);
        foreach (addrs[i]) begin
            issue(1'b0, addrs[i] & 12'h0ff, '0);
        end
        end_test();
    endtask

    initial begin
        seed         = 32'h3d64226f;
        rst          = 1'b1;
        req          = '0;
        cycle        = 0;
        credits      = bus_pkg::BUS_CREDITS;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        aborted      = 1'b0;
        test_name    = "setup";
        disp_model   = '0;
        video_model[0] = periph_pkg::VIDEO_CTL_DEFAULT;
        video_model[1] = periph_pkg::CRX_DEFAULT;
        video_model[2] = periph_pkg::CRY_DEFAULT;
        foreach (ram_written[i]) ram_written[i] = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        reset_values_test();
        if (!aborted) begin
            ram_traffic_test();
        end
        if (!aborted) begin
            video_reg_test();
        end
        if (!aborted) begin
            display_scan_test();
        end
        if (!aborted) begin
            unmapped_test();
        end
        $display("Summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
verilog/bus_pkg.sv
verilog/periph_pkg.sv
verilog/mmio_decode.sv
verilog/block_ram.sv
verilog/ctl_regs.sv
verilog/seg7_display.sv
verilog/periph_top.sv
dv/periph_tb.sv
